// ==== flist.f ====
source/qic_tape_pkg.sv
source/qic_if.sv
source/qic_input_stage.sv
source/qic_motion_fsm.sv
source/qic_position_tracker.sv
source/qic_status_out.sv
source/qic_tape_top.sv
tb/qic_tape_checker.sv
tb/tb_qic_tape.sv

// ==== source/qic_if.sv ====
// No back-pressure on either bus; req and index_step are single-cycle strobes
`timescale 1ns/1ps

// ======================================================================
// Decoded command and index strobe, input stage to FSM and tracker
// ======================================================================
interface motion_req_if import qic_tape_pkg::*; ();
    logic     req;         // One cycle per accepted command
    tape_op_t op;
    logic     rev;         // Reverse bit of the command
    logic     index_step;  // Index rising edge seen

    modport source (output req, op, rev, index_step);
    modport sink (input req, op, rev);
    modport monitor (input index_step);
endinterface

// ======================================================================
// Position control, FSM to tracker and tape-end flags back
// ======================================================================
interface pos_ctl_if ();
    logic count_en;     // Count segments on index
    logic count_rev;    // Held direction, 1 is reverse
    logic skip_step;    // Step one segment now
    logic track_next;
    logic track_home;
    logic mark_set;
    logic mark_clear;
    logic at_first_seg;
    logic at_last_seg;
    logic at_first_track;
    logic at_last_track;

    modport ctrl (
        output count_en, count_rev, skip_step, track_next, track_home, mark_set, mark_clear,
        input  at_first_seg, at_last_seg, at_first_track, at_last_track
    );
    modport track (
        input  count_en, count_rev, skip_step, track_next, track_home, mark_set, mark_clear,
        output at_first_seg, at_last_seg, at_first_track, at_last_track
    );
endinterface

// ==== source/qic_input_stage.sv ====
// command_valid must be a one-cycle strobe; any code outside the motion set is acknowledged
`timescale 1ns/1ps

module qic_input_stage import qic_tape_pkg::*; (
    input  logic          clk,
    input  logic          reset_n,
    input  logic          enable,
    input  cmd_code_t     command,
    input  logic          command_valid,
    input  logic          index_pulse,
    motion_req_if.source  req
);

    tape_op_t op_dec;
    logic     rev_dec;
    logic     index_q;  // Previous index level

    always_comb begin
        rev_dec = 1'b0;
        case (command)
            CMD_SEEK_BOT:      op_dec = OP_SEEK_BOT;
            CMD_SEEK_EOT:      op_dec = OP_SEEK_EOT;
            CMD_SKIP_FWD_SEG:  op_dec = OP_SKIP_SEG;
            CMD_SKIP_FWD_FILE: op_dec = OP_SKIP_FILE;
            CMD_LOGICAL_FWD:   op_dec = OP_STREAM;
            CMD_SKIP_REV_SEG: begin
                op_dec  = OP_SKIP_SEG;
                rev_dec = 1'b1;
            end
            CMD_SKIP_REV_FILE: begin
                op_dec  = OP_SKIP_FILE;
                rev_dec = 1'b1;
            end
            CMD_LOGICAL_REV: begin
                op_dec  = OP_STREAM;
                rev_dec = 1'b1;
            end
            CMD_PAUSE, CMD_STOP: op_dec = OP_ABORT;
            CMD_RESET:           op_dec = OP_ACK;  // Nothing latched to clear
            default:             op_dec = OP_ACK;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            req.req        <= 1'b0;
            req.op         <= OP_NONE;
            req.rev        <= 1'b0;
            req.index_step <= 1'b0;
            index_q        <= 1'b0;
        end else begin
            req.req        <= command_valid && enable;  // Dropped while disabled
            req.op         <= op_dec;
            req.rev        <= rev_dec;
            index_q        <= index_pulse;
            req.index_step <= index_pulse && !index_q;
        end
    end

    // Host keeps command_valid to a single cycle
    a_req_single: assert property (@(posedge clk) disable iff (!reset_n)
        req.req |=> !req.req)
        else $error("req held high for two cycles");

endmodule

// ==== source/qic_motion_fsm.sv ====
// Delays are clock-cycle counts below 2**TIMER_WIDTH; each timed state adds one load cycle
`timescale 1ns/1ps

module qic_motion_fsm import qic_tape_pkg::*; #(
    parameter int SPINUP_CYCLES       = 10_000_000,
    parameter int STOP_CYCLES         = 5_000_000,
    parameter int SKIP_CYCLES         = 2_000_000,
    parameter int TRACK_CHANGE_CYCLES = 16_000_000
) (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        enable,
    input  logic        file_mark_detect,
    motion_req_if.sink  req,
    pos_ctl_if.ctrl     pos,
    output fsm_state_t  state,
    output logic        direction,   // 1 is reverse
    output logic        done_evt,
    output logic        error_evt
);

    fsm_state_t             target;      // State after spin-up
    fsm_state_t             prev_state;
    logic                   fail_q;      // Error pending for stopping
    logic [TIMER_WIDTH-1:0] timer;
    logic [TIMER_WIDTH-1:0] tmr_dur;
    logic                   tmr_load;
    logic                   entered;
    logic                   expired;
    logic                   at_end;      // Tape end ahead of the motion
    logic                   abort_req;
    logic                   moving;

    assign entered   = state != prev_state;
    assign expired   = !entered && timer == '0;
    assign at_end    = direction ? pos.at_first_seg : pos.at_last_seg;
    assign abort_req = req.req && req.op == OP_ABORT;
    assign moving    = state inside {ST_SEEK, ST_SKIP_SEG, ST_SKIP_FILE, ST_STREAM,
                                     ST_TRACK_CHANGE};

    // ==================================================================
    // Delay timer, loaded on entry to a timed state
    // ==================================================================
    always_comb begin
        tmr_load = entered;
        case (state)
            ST_SPINUP:       tmr_dur = TIMER_WIDTH'(SPINUP_CYCLES);
            ST_SKIP_SEG:     tmr_dur = TIMER_WIDTH'(SKIP_CYCLES);
            ST_TRACK_CHANGE: tmr_dur = TIMER_WIDTH'(TRACK_CHANGE_CYCLES);
            ST_STOPPING:     tmr_dur = TIMER_WIDTH'(STOP_CYCLES);
            default: begin
                tmr_dur  = '0;
                tmr_load = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            timer      <= '0;
            prev_state <= ST_IDLE;
        end else begin
            prev_state <= state;
            if (tmr_load)
                timer <= tmr_dur;
            else if (timer != '0)
                timer <= timer - 1'b1;
        end
    end

    // Position control
    assign pos.count_en   = state inside {ST_SEEK, ST_SKIP_FILE, ST_STREAM};
    assign pos.count_rev  = direction;
    assign pos.skip_step  = state == ST_SKIP_SEG && expired;
    assign pos.track_next = state == ST_TRACK_CHANGE && expired;
    assign pos.track_home = state == ST_SEEK && direction && pos.at_first_seg;
    assign pos.mark_set   = state == ST_SKIP_FILE && file_mark_detect;
    assign pos.mark_clear = state == ST_SPINUP;

    // ==================================================================
    // Main state machine
    // ==================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= ST_IDLE;
            target    <= ST_IDLE;
            direction <= 1'b0;
            fail_q    <= 1'b0;
            done_evt  <= 1'b0;
            error_evt <= 1'b0;
        end else if (!enable) begin
            state     <= ST_IDLE;  // Position kept, motion dropped
            fail_q    <= 1'b0;
            done_evt  <= 1'b0;
            error_evt <= 1'b0;
        end else begin
            done_evt  <= 1'b0;
            error_evt <= 1'b0;
            case (state)
                ST_IDLE: if (req.req) begin
                    case (req.op)
                        OP_SEEK_BOT, OP_SEEK_EOT: begin
                            direction <= req.op == OP_SEEK_BOT;
                            target    <= ST_SEEK;
                            state     <= ST_SPINUP;
                        end
                        OP_SKIP_SEG: begin
                            if (req.rev ? pos.at_first_seg : pos.at_last_seg) begin
                                error_evt <= 1'b1;  // Refused at tape end
                            end else begin
                                direction <= req.rev;
                                target    <= ST_SKIP_SEG;
                                state     <= ST_SPINUP;
                            end
                        end
                        OP_SKIP_FILE, OP_STREAM: begin
                            direction <= req.rev;
                            target    <= (req.op == OP_STREAM) ? ST_STREAM : ST_SKIP_FILE;
                            state     <= ST_SPINUP;
                        end
                        default: done_evt <= 1'b1;  // Ack, stop or pause at rest
                    endcase
                end
                ST_SPINUP:   if (expired) state <= target;
                ST_SEEK:     if (at_end) state <= ST_STOPPING;
                ST_SKIP_SEG: if (expired) state <= ST_STOPPING;
                ST_SKIP_FILE: begin
                    if (file_mark_detect) begin
                        state <= ST_STOPPING;
                    end else if (at_end) begin
                        fail_q <= 1'b1;
                        state  <= ST_STOPPING;
                    end
                end
                ST_STREAM: begin
                    // Serpentine turn while tracks remain
                    if (at_end)
                        state <= (direction ? pos.at_first_track : pos.at_last_track) ?
                                 ST_STOPPING : ST_TRACK_CHANGE;
                    else if (req.req && req.op == OP_STREAM)
                        direction <= req.rev;
                end
                ST_TRACK_CHANGE: begin
                    if (expired) begin
                        direction <= !direction;
                        state     <= ST_STREAM;
                    end
                end
                ST_STOPPING: begin
                    if (expired && fail_q) begin
                        error_evt <= 1'b1;  // One cycle ahead of done
                        fail_q    <= 1'b0;
                    end else if (expired) begin
                        done_evt <= 1'b1;
                        state    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
            if (abort_req && moving)
                state <= ST_STOPPING;
        end
    end

    // Timer only runs down in timed states, or in idle after an enable drop
    a_timer_state: assert property (@(posedge clk) disable iff (!reset_n)
        timer != '0 |-> state inside {ST_IDLE, ST_SPINUP, ST_SKIP_SEG, ST_TRACK_CHANGE,
                                      ST_STOPPING})
        else $error("delay timer running in state %s", state.name());

endmodule

// ==== source/qic_position_tracker.sv ====
// Segments run 0 to MAX_SEGMENTS and tracks 0 to MAX_TRACKS; counts clamp at both ends
`timescale 1ns/1ps

module qic_position_tracker import qic_tape_pkg::*; #(
    parameter int MAX_SEGMENTS = 4095,
    parameter int MAX_TRACKS   = 27
) (
    input  logic                     clk,
    input  logic                     reset_n,
    motion_req_if.monitor            index_step,
    pos_ctl_if.track                 pos,
    output logic [SEGMENT_WIDTH-1:0] segment,
    output logic [TRACK_WIDTH-1:0]   track,
    output logic                     at_bot,
    output logic                     at_eot,
    output logic                     at_file_mark
);

    logic seg_step;
    logic first_track;
    logic last_track;

    assign at_bot      = segment == '0;
    assign at_eot      = segment == SEGMENT_WIDTH'(MAX_SEGMENTS);
    assign first_track = track == '0;
    assign last_track  = track == TRACK_WIDTH'(MAX_TRACKS);

    assign pos.at_first_seg   = at_bot;
    assign pos.at_last_seg    = at_eot;
    assign pos.at_first_track = first_track;
    assign pos.at_last_track  = last_track;

    // Index counting while moving, or a single timed skip
    assign seg_step = (index_step.index_step && pos.count_en) || pos.skip_step;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            segment <= '0;
        end else if (seg_step) begin
            if (pos.count_rev && !at_bot)
                segment <= segment - 1'b1;
            else if (!pos.count_rev && !at_eot)
                segment <= segment + 1'b1;
        end
    end

    // Track follows the direction held before the turn
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            track <= '0;
        end else if (pos.track_home) begin
            track <= '0;
        end else if (pos.track_next) begin
            if (pos.count_rev && !first_track)
                track <= track - 1'b1;
            else if (!pos.count_rev && !last_track)
                track <= track + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            at_file_mark <= 1'b0;
        else if (pos.mark_clear)
            at_file_mark <= 1'b0;  // New motion leaves the mark
        else if (pos.mark_set)
            at_file_mark <= 1'b1;
    end

    a_seg_range: assert property (@(posedge clk) disable iff (!reset_n)
        segment <= SEGMENT_WIDTH'(MAX_SEGMENTS))
        else $error("segment %0d beyond MAX_SEGMENTS", segment);

endmodule

// ==== source/qic_status_out.sv ====
// All outputs are registered one cycle after the FSM and held inactive while disabled
`timescale 1ns/1ps

module qic_status_out import qic_tape_pkg::*; (
    input  logic         clk,
    input  logic         reset_n,
    input  logic         enable,
    input  fsm_state_t   state,
    input  logic         done_evt,
    input  logic         error_evt,
    output logic         motor_on,
    output logic         tape_moving,
    output motion_mode_t motion_mode,
    output logic         command_done,
    output logic         command_error
);

    motion_mode_t mode_next;

    always_comb begin
        case (state)
            ST_SEEK, ST_TRACK_CHANGE:  mode_next = MODE_SEEK;  // Head move counts as seek
            ST_SKIP_SEG, ST_SKIP_FILE: mode_next = MODE_SKIP;
            ST_STREAM:                 mode_next = MODE_STREAM;
            default:                   mode_next = MODE_STOP;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            motor_on      <= 1'b0;
            tape_moving   <= 1'b0;
            motion_mode   <= MODE_STOP;
            command_done  <= 1'b0;
            command_error <= 1'b0;
        end else begin
            motor_on      <= enable && state != ST_IDLE;
            tape_moving   <= enable && state inside {ST_SEEK, ST_SKIP_SEG, ST_SKIP_FILE,
                                                     ST_STREAM};
            motion_mode   <= enable ? mode_next : MODE_STOP;
            command_done  <= enable && done_evt;
            command_error <= enable && error_evt;
        end
    end

endmodule

// ==== source/qic_tape_pkg.sv ====
// Motion subset of QIC-117 only; widths assume at most 65535 segments and 31 tracks
package qic_tape_pkg;

    // ==================================================================
    // Widths
    // ==================================================================
    localparam int SEGMENT_WIDTH = 16;
    localparam int TRACK_WIDTH   = 5;
    localparam int TIMER_WIDTH   = 24;  // Longest delay is 2**24-1 cycles

    // ==================================================================
    // QIC-117 command codes
    // ==================================================================
    typedef logic [5:0] cmd_code_t;

    localparam cmd_code_t CMD_RESET         = 6'd1;
    localparam cmd_code_t CMD_PAUSE         = 6'd6;
    localparam cmd_code_t CMD_SEEK_BOT      = 6'd8;
    localparam cmd_code_t CMD_SEEK_EOT      = 6'd9;
    localparam cmd_code_t CMD_SKIP_REV_SEG  = 6'd10;
    localparam cmd_code_t CMD_SKIP_REV_FILE = 6'd11;
    localparam cmd_code_t CMD_SKIP_FWD_SEG  = 6'd12;
    localparam cmd_code_t CMD_SKIP_FWD_FILE = 6'd13;
    localparam cmd_code_t CMD_LOGICAL_FWD   = 6'd21;
    localparam cmd_code_t CMD_LOGICAL_REV   = 6'd22;
    localparam cmd_code_t CMD_STOP          = 6'd23;

    // Decoded operation, direction travels separately
    typedef enum logic [2:0] {
        OP_NONE,
        OP_ACK,        // Reset and unknown codes
        OP_SEEK_BOT,
        OP_SEEK_EOT,
        OP_SKIP_SEG,
        OP_SKIP_FILE,
        OP_STREAM,
        OP_ABORT       // Pause or stop
    } tape_op_t;

    typedef enum logic [1:0] {
        MODE_STOP,
        MODE_SEEK,
        MODE_SKIP,
        MODE_STREAM
    } motion_mode_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SPINUP,
        ST_SEEK,
        ST_SKIP_SEG,
        ST_SKIP_FILE,
        ST_STREAM,
        ST_TRACK_CHANGE,
        ST_STOPPING
    } fsm_state_t;

endpackage

// ==== source/qic_tape_top.sv ====
// Cycle parameters must fit TIMER_WIDTH; done follows an ack three edges after command_valid
`timescale 1ns/1ps

module qic_tape_top import qic_tape_pkg::*; #(
    parameter int MAX_SEGMENTS        = 4095,
    parameter int MAX_TRACKS          = 27,
    parameter int SPINUP_CYCLES       = 10_000_000,
    parameter int STOP_CYCLES         = 5_000_000,
    parameter int SKIP_CYCLES         = 2_000_000,
    parameter int TRACK_CHANGE_CYCLES = 16_000_000
) (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     enable,
    input  cmd_code_t                command,
    input  logic                     command_valid,
    input  logic                     index_pulse,
    input  logic                     file_mark_detect,
    output logic                     command_done,
    output logic                     command_error,
    output logic [SEGMENT_WIDTH-1:0] segment,
    output logic [TRACK_WIDTH-1:0]   track,
    output logic                     direction,
    output logic                     at_bot,
    output logic                     at_eot,
    output logic                     at_file_mark,
    output logic                     motor_on,
    output logic                     tape_moving,
    output motion_mode_t             motion_mode
);

    motion_req_if req_bus ();
    pos_ctl_if    pos_bus ();

    fsm_state_t fsm_state;
    logic       done_evt;
    logic       error_evt;

    qic_input_stage qic_input_stage_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .enable        (enable),
        .command       (command),
        .command_valid (command_valid),
        .index_pulse   (index_pulse),
        .req           (req_bus.source)
    );

    qic_motion_fsm #(
        .SPINUP_CYCLES       (SPINUP_CYCLES),
        .STOP_CYCLES         (STOP_CYCLES),
        .SKIP_CYCLES         (SKIP_CYCLES),
        .TRACK_CHANGE_CYCLES (TRACK_CHANGE_CYCLES)
    ) qic_motion_fsm_i (
        .clk              (clk),
        .reset_n          (reset_n),
        .enable           (enable),
        .file_mark_detect (file_mark_detect),
        .req              (req_bus.sink),
        .pos              (pos_bus.ctrl),
        .state            (fsm_state),
        .direction        (direction),
        .done_evt         (done_evt),
        .error_evt        (error_evt)
    );

    qic_position_tracker #(
        .MAX_SEGMENTS (MAX_SEGMENTS),
        .MAX_TRACKS   (MAX_TRACKS)
    ) qic_position_tracker_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .index_step   (req_bus.monitor),
        .pos          (pos_bus.track),
        .segment      (segment),
        .track        (track),
        .at_bot       (at_bot),
        .at_eot       (at_eot),
        .at_file_mark (at_file_mark)
    );

    qic_status_out qic_status_out_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .enable        (enable),
        .state         (fsm_state),
        .done_evt      (done_evt),
        .error_evt     (error_evt),
        .motor_on      (motor_on),
        .tape_moving   (tape_moving),
        .motion_mode   (motion_mode),
        .command_done  (command_done),
        .command_error (command_error)
    );

endmodule

// ==== tb/qic_tape_checker.sv ====
// Compares DUT state after each table row; latencies count the sampling edge as the first
`timescale 1ns/1ps

module qic_tape_checker import qic_tape_pkg::*; #(
    parameter int MAX_SEGMENTS = 12
) (
    input  logic                     clk,
    input  logic                     enable,
    input  logic                     command_valid,
    input  logic                     command_done,
    input  logic                     command_error,
    input  logic [SEGMENT_WIDTH-1:0] segment,
    input  logic [TRACK_WIDTH-1:0]   track,
    input  logic                     direction,
    input  logic                     at_bot,
    input  logic                     at_eot,
    input  logic                     at_file_mark,
    input  logic                     motor_on,
    input  logic                     tape_moving,
    input  motion_mode_t             motion_mode,
    input  logic                     row_start,   // Clears the strobe history
    input  logic                     row_check,   // Compare now
    input  int                       exp_seg,
    input  int                       exp_trk,
    input  int                       exp_dir,
    input  int                       exp_mark,
    input  int                       exp_err,
    input  int                       exp_done,
    input  int                       exp_lat,     // 0 leaves latency unchecked
    output int                       error_count
);

    int   edge_cnt = 0;
    int   valid_edge = 0;   // Edge before the one that sampled the last command
    int   done_lat = 0;
    int   err_lat = 0;
    logic done_seen = 1'b0;
    logic err_seen = 1'b0;

    initial error_count = 0;

    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            error_count++;
        end
    endtask

    task compare_row();
        expect_equal("segment", segment, exp_seg);
        expect_equal("track", track, exp_trk);
        expect_equal("direction", direction, exp_dir);
        expect_equal("at_bot", at_bot, exp_seg == 0);
        expect_equal("at_eot", at_eot, exp_seg == MAX_SEGMENTS);
        expect_equal("at_file_mark", at_file_mark, exp_mark);
        expect_equal("command_done seen", done_seen, exp_done != 0);
        expect_equal("command_error seen", err_seen, exp_err != 0);
        // Drive is at rest after every row
        expect_equal("motor_on", motor_on, 0);
        expect_equal("tape_moving", tape_moving, 0);
        expect_equal("motion_mode", motion_mode, MODE_STOP);
        expect_equal("command_done level", command_done, 0);
        expect_equal("command_error level", command_error, 0);
        if (exp_lat != 0)
            expect_equal("strobe latency", (exp_done != 0) ? done_lat : err_lat, exp_lat);
        if (exp_err != 0 && exp_done != 0)
            expect_equal("done after error", done_lat - err_lat, 1);  // Error leads by one
    endtask

    always @(posedge clk)
        edge_cnt <= edge_cnt + 1;

    // Inputs change on the falling edge by nonblocking writes, so the
    // values seen here are the ones the DUT sampled on the last rising edge
    always @(negedge clk) begin
        if (row_start) begin
            done_seen = 1'b0;
            err_seen  = 1'b0;
            done_lat  = 0;
            err_lat   = 0;
        end
        if (command_valid && enable)
            valid_edge = edge_cnt - 1;  // Sampling edge is edge one
        if (command_done && !done_seen) begin
            done_seen = 1'b1;
            done_lat  = edge_cnt - valid_edge;
        end
        if (command_error && !err_seen) begin
            err_seen = 1'b1;
            err_lat  = edge_cnt - valid_edge;
        end
        // A moving tape needs the motor and a motion mode
        if (tape_moving === 1'b1 && (motor_on !== 1'b1 || motion_mode === MODE_STOP)) begin
            $display("CHECK FAILED at %0t ns: tape moving with motor_on %0b, motion_mode %0d",
                     $time, motor_on, motion_mode);
            error_count++;
        end
        if (row_check)
            compare_row();
    end

endmodule

// ==== tb/tb_qic_tape.sv ====
// Short tape of segments 0 to 12 and tracks 0 to 2; each row waits at most TIMEOUT cycles
`timescale 1ns/1ps

module tb_qic_tape import qic_tape_pkg::*; ();

    localparam int MAX_SEG = 12;
    localparam int TIMEOUT = 400;

    typedef struct packed {
        int        send;      // 0 checks state without a command
        cmd_code_t cmd;
        int        mark_seg;  // File mark position, -1 for none
        int        evt_seg;   // Event segment, taken on track exp_trk
        int        evt_kind;  // 0 none, 1 stop command, 2 enable drop
        int        exp_seg;
        int        exp_trk;
        int        exp_dir;
        int        exp_mark;
        int        exp_err;
        int        exp_done;
        int        exp_lat;
    } row_t;

    logic                     clk;
    logic                     reset_n;
    logic                     enable;
    cmd_code_t                command;
    logic                     command_valid;
    logic                     index_pulse = 1'b0;
    logic                     file_mark_detect = 1'b0;
    logic                     command_done;
    logic                     command_error;
    logic [SEGMENT_WIDTH-1:0] segment;
    logic [TRACK_WIDTH-1:0]   track;
    logic                     direction;
    logic                     at_bot;
    logic                     at_eot;
    logic                     at_file_mark;
    logic                     motor_on;
    logic                     tape_moving;
    motion_mode_t             motion_mode;

    row_t rows [0:31];
    row_t cur;
    int   n_rows = 0;
    int   idx_cnt = 0;
    int   timeouts = 0;
    int   error_count;
    logic row_start = 1'b0;
    logic row_check = 1'b0;

    qic_tape_top #(
        .MAX_SEGMENTS        (MAX_SEG),
        .MAX_TRACKS          (2),
        .SPINUP_CYCLES       (4),
        .STOP_CYCLES         (5),
        .SKIP_CYCLES         (6),
        .TRACK_CHANGE_CYCLES (8)
    ) qic_tape_top_i (.*);

    qic_tape_checker #(
        .MAX_SEGMENTS (MAX_SEG)
    ) qic_tape_checker_i (
        .*,
        .exp_seg  (cur.exp_seg),
        .exp_trk  (cur.exp_trk),
        .exp_dir  (cur.exp_dir),
        .exp_mark (cur.exp_mark),
        .exp_err  (cur.exp_err),
        .exp_done (cur.exp_done),
        .exp_lat  (cur.exp_lat)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Index pulse every 6 cycles while the tape moves
    always @(negedge clk) begin
        if (tape_moving !== 1'b1) begin
            idx_cnt     <= 0;
            index_pulse <= 1'b0;
        end else begin
            idx_cnt     <= (idx_cnt == 5) ? 0 : idx_cnt + 1;
            index_pulse <= idx_cnt == 5;
        end
    end

    always @(negedge clk)
        file_mark_detect <= cur.mark_seg >= 0 && segment == cur.mark_seg &&
                            motion_mode == MODE_SKIP;

    task automatic add_row(input int send, input cmd_code_t cmd, input int mark_seg, evt_seg,
                           evt_kind, exp_seg, exp_trk, exp_dir, exp_mark, exp_err,
                           exp_done, exp_lat);
        rows[n_rows] = '{send, cmd, mark_seg, evt_seg, evt_kind, exp_seg, exp_trk, exp_dir,
                         exp_mark, exp_err, exp_done, exp_lat};
        n_rows++;
    endtask

    task automatic run_row(input int i);
        int cyc;
        bit fired;
        bit finished;
        @(negedge clk);
        cur           <= rows[i];
        command       <= rows[i].cmd;
        command_valid <= rows[i].send != 0;
        enable        <= 1'b1;
        row_start     <= 1'b1;
        fired    = 1'b0;
        finished = 1'b0;
        cyc      = 0;
        while (!finished && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
            row_start     <= 1'b0;
            command_valid <= 1'b0;
            if (!fired && rows[i].evt_kind != 0 && tape_moving &&
                    track == rows[i].exp_trk && segment == rows[i].evt_seg) begin
                fired = 1'b1;
                if (rows[i].evt_kind == 1) begin
                    command       <= CMD_STOP;
                    command_valid <= 1'b1;
                end else begin
                    enable <= 1'b0;  // Drop mid-motion
                end
            end
            if (rows[i].exp_done != 0)
                finished = command_done;
            else if (rows[i].exp_err != 0)
                finished = command_error;
            else
                finished = rows[i].send == 0 || fired;  // Outputs registered one edge later
        end
        if (!finished) begin
            $display("Timeout: row %0d did not complete within %0d cycles", i, TIMEOUT);
            timeouts++;
        end
        row_check <= 1'b1;
        @(negedge clk);
        row_check <= 1'b0;
    endtask

    initial begin
        reset_n       = 1'b0;
        enable        = 1'b1;
        command       = CMD_RESET;
        command_valid = 1'b0;
        // send cmd mark evt_seg evt_kind | seg trk dir mark err done lat
        add_row(0, CMD_RESET, -1, -1, 0, 0, 0, 0, 0, 0, 0, 0);  // Reset values
        add_row(1, CMD_RESET, -1, -1, 0, 0, 0, 0, 0, 0, 1, 3);
        add_row(1, CMD_STOP, -1, -1, 0, 0, 0, 0, 0, 0, 1, 3);
        add_row(1, 6'd40, -1, -1, 0, 0, 0, 0, 0, 0, 1, 3);      // Unknown code
        add_row(1, CMD_SEEK_EOT, -1, -1, 0, 12, 0, 0, 0, 0, 1, 0);
        add_row(1, CMD_SEEK_BOT, -1, -1, 0, 0, 0, 1, 0, 0, 1, 0);
        add_row(1, CMD_SKIP_REV_SEG, -1, -1, 0, 0, 0, 1, 0, 1, 0, 3);
        add_row(1, CMD_SKIP_FWD_SEG, -1, -1, 0, 1, 0, 0, 0, 0, 1, 0);
        add_row(1, CMD_SKIP_FWD_SEG, -1, -1, 0, 2, 0, 0, 0, 0, 1, 0);
        add_row(1, CMD_SKIP_REV_SEG, -1, -1, 0, 1, 0, 1, 0, 0, 1, 0);
        add_row(1, CMD_SKIP_FWD_FILE, 5, -1, 0, 5, 0, 0, 1, 0, 1, 0);
        add_row(1, CMD_SKIP_FWD_FILE, -1, -1, 0, 12, 0, 0, 0, 1, 1, 0);  // No mark ahead
        add_row(1, CMD_SKIP_FWD_SEG, -1, -1, 0, 12, 0, 0, 0, 1, 0, 3);
        add_row(1, CMD_SKIP_REV_FILE, 8, -1, 0, 8, 0, 1, 1, 0, 1, 0);
        add_row(1, CMD_SEEK_BOT, -1, -1, 0, 0, 0, 1, 0, 0, 1, 0);
        add_row(1, CMD_LOGICAL_FWD, -1, 9, 1, 9, 1, 1, 0, 0, 1, 0);  // Stop on the way back
        add_row(1, CMD_SEEK_BOT, -1, 5, 2, 5, 1, 1, 0, 0, 0, 0);
        add_row(1, CMD_SEEK_BOT, -1, -1, 0, 0, 0, 1, 0, 0, 1, 0);
        cur = rows[0];
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_n <= 1'b1;
        for (int i = 0; i < n_rows; i++)
            run_row(i);
        repeat (2) @(negedge clk);
        $display("Result: %0d mismatches, %0d timeouts", error_count, timeouts);
        if (error_count == 0 && timeouts == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule
